// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_decode_top
DUT_TOP   ?= decode_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps
PASS_MSG  := === PASS ===

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: design/control_unit.sv
`timescale 1ns/1ps

module control_unit
    import decode_pkg::*;
(
    input  if_id_t      i_if_id,
    output id_ex_ctrl_t o_id_ex_ctrl
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [15:0]        imm;
    logic [NB_ADDR-1:0] rs;
    logic [NB_ADDR-1:0] rt;
    logic [NB_ADDR-1:0] rd;
    logic [NB_DATA-1:0] imm_sign;
    logic [NB_DATA-1:0] imm_zero;

    assign opcode = i_if_id.instruction[31:26];
    assign rs     = i_if_id.instruction[25:21];
    assign rt     = i_if_id.instruction[20:16];
    assign rd     = i_if_id.instruction[15:11];
    assign funct  = i_if_id.instruction[5:0];
    assign imm    = i_if_id.instruction[15:0];

    assign imm_sign = {{(NB_DATA-16){imm[15]}}, imm};
    assign imm_zero = {{(NB_DATA-16){1'b0}}, imm};

    // An unknown opcode or funct leaves the whole bundle at zero, same as a flush
    always_comb begin
        o_id_ex_ctrl      = '0;
        o_id_ex_ctrl.rs   = rs;
        o_id_ex_ctrl.rt   = rt;
        o_id_ex_ctrl.dest = rt;
        o_id_ex_ctrl.pc   = i_if_id.pc;
        case (opcode)
            OP_RTYPE: begin
                o_id_ex_ctrl.dest           = rd;  // R-type writes rd
                o_id_ex_ctrl.ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD: o_id_ex_ctrl.ctrl.alu_op = ALU_ADD;
                    FN_SUB: o_id_ex_ctrl.ctrl.alu_op = ALU_SUB;
                    FN_AND: o_id_ex_ctrl.ctrl.alu_op = ALU_AND;
                    FN_OR:  o_id_ex_ctrl.ctrl.alu_op = ALU_OR;
                    FN_SLT: o_id_ex_ctrl.ctrl.alu_op = ALU_SLT;
                    default: o_id_ex_ctrl = '0;
                endcase
            end
            OP_ADDI: begin
                o_id_ex_ctrl.ctrl.reg_write = 1'b1;
                o_id_ex_ctrl.ctrl.alu_src   = 1'b1;
                o_id_ex_ctrl.ctrl.alu_op    = ALU_ADD;
                o_id_ex_ctrl.immediate      = imm_sign;
            end
            OP_ANDI: begin
                o_id_ex_ctrl.ctrl.reg_write = 1'b1;
                o_id_ex_ctrl.ctrl.alu_src   = 1'b1;
                o_id_ex_ctrl.ctrl.alu_op    = ALU_AND;
                o_id_ex_ctrl.immediate      = imm_zero;  // Logical ops zero-extend
            end
            OP_ORI: begin
                o_id_ex_ctrl.ctrl.reg_write = 1'b1;
                o_id_ex_ctrl.ctrl.alu_src   = 1'b1;
                o_id_ex_ctrl.ctrl.alu_op    = ALU_OR;
                o_id_ex_ctrl.immediate      = imm_zero;
            end
            OP_LUI: begin
                o_id_ex_ctrl.ctrl.reg_write = 1'b1;
                o_id_ex_ctrl.ctrl.alu_src   = 1'b1;
                o_id_ex_ctrl.ctrl.alu_op    = ALU_LUI;
                o_id_ex_ctrl.immediate      = imm_zero << 16;  // Upper half
            end
            OP_LW: begin
                o_id_ex_ctrl.ctrl.reg_write  = 1'b1;
                o_id_ex_ctrl.ctrl.mem_read   = 1'b1;
                o_id_ex_ctrl.ctrl.mem_to_reg = 1'b1;
                o_id_ex_ctrl.ctrl.alu_src    = 1'b1;
                o_id_ex_ctrl.ctrl.alu_op     = ALU_ADD;  // Base plus offset
                o_id_ex_ctrl.immediate       = imm_sign;
            end
            OP_SW: begin
                o_id_ex_ctrl.ctrl.mem_write = 1'b1;
                o_id_ex_ctrl.ctrl.alu_src   = 1'b1;
                o_id_ex_ctrl.ctrl.alu_op    = ALU_ADD;
                o_id_ex_ctrl.immediate      = imm_sign;
            end
            OP_BEQ: begin
                o_id_ex_ctrl.ctrl.branch = 1'b1;
                o_id_ex_ctrl.ctrl.alu_op = ALU_SUB;  // Compare by subtraction
                o_id_ex_ctrl.immediate   = imm_sign;
            end
            default: o_id_ex_ctrl = '0;
        endcase
    end

endmodule

// File: design/decode_pkg.sv
package decode_pkg;

    // Default widths, picked up by the top-level parameters
    localparam int NB_DATA    = 32;
    localparam int NB_ADDR    = 5;
    localparam int BANK_DEPTH = 32;
    localparam int NB_PC      = 32;
    localparam int NB_INSTR   = 32;

    // Opcodes of the supported subset
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct codes
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,  // Also the bubble value
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;     // Immediate as operand B
        logic    branch;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [NB_INSTR-1:0] instruction;
        logic [NB_PC-1:0]    pc;
    } if_id_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [NB_DATA-1:0]  immediate;
        logic [NB_ADDR-1:0]  rs;
        logic [NB_ADDR-1:0]  rt;
        logic [NB_ADDR-1:0]  dest;
        logic [NB_PC-1:0]    pc;
    } id_ex_ctrl_t;

    typedef struct packed {
        id_ex_ctrl_t         decoded;
        logic [NB_DATA-1:0]  data_a;
        logic [NB_DATA-1:0]  data_b;
    } id_ex_t;

endpackage

// File: design/decode_top.sv
`timescale 1ns/1ps

module decode_top
    import decode_pkg::*;
#(
    parameter int NB_DATA    = decode_pkg::NB_DATA,
    parameter int NB_ADDR    = decode_pkg::NB_ADDR,
    parameter int BANK_DEPTH = decode_pkg::BANK_DEPTH,
    parameter int NB_PC      = decode_pkg::NB_PC
) (
    input  logic               i_clock,
    input  logic               i_reset,
    input  logic               i_enable,         // Debug unit step level
    input  logic               i_flush,
    input  logic [31:0]        i_instruction,
    input  logic [NB_PC-1:0]   i_pc,
    input  logic               i_wb_write,
    input  logic [NB_ADDR-1:0] i_wb_reg,
    input  logic [NB_DATA-1:0] i_wb_data,
    input  logic               i_debug_read,
    input  logic [NB_ADDR-1:0] i_debug_address,
    output id_ex_t             o_id_ex,
    output logic [NB_DATA-1:0] o_debug_data
);

    if_id_t             if_id_d;
    if_id_t             if_id_q;
    id_ex_ctrl_t        id_ex_ctrl_d;
    id_ex_ctrl_t        id_ex_ctrl_q;
    logic [NB_DATA-1:0] data_a;
    logic [NB_DATA-1:0] data_b;

    assign if_id_d.instruction = i_instruction;
    assign if_id_d.pc          = i_pc;

    pipeline_register #(
        .payload_t (if_id_t)
    ) u_if_id (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (i_enable),
        .i_flush  (1'b0),    // Flush only acts on ID/EX
        .i_data   (if_id_d),
        .o_data   (if_id_q)
    );

    control_unit u_control (
        .i_if_id      (if_id_q),
        .o_id_ex_ctrl (id_ex_ctrl_d)
    );

    // Operand reads share the edge that loads ID/EX
    registers_bank #(
        .NB_DATA    (NB_DATA),
        .NB_ADDR    (NB_ADDR),
        .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_enable        (i_enable),
        .i_reg_write     (i_wb_write),
        .i_read_reg_a    (if_id_q.instruction[25:21]),  // rs
        .i_read_reg_b    (if_id_q.instruction[20:16]),  // rt
        .i_write_reg     (i_wb_reg),
        .i_write_data    (i_wb_data),
        .i_debug_read    (i_debug_read),
        .i_debug_address (i_debug_address),
        .o_data_a        (data_a),
        .o_data_b        (data_b),
        .o_debug_data    (o_debug_data)
    );

    pipeline_register #(
        .payload_t (id_ex_ctrl_t)
    ) u_id_ex (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (i_enable),
        .i_flush  (i_flush),
        .i_data   (id_ex_ctrl_d),
        .o_data   (id_ex_ctrl_q)
    );

    assign o_id_ex.decoded = id_ex_ctrl_q;
    assign o_id_ex.data_a  = data_a;
    assign o_id_ex.data_b  = data_b;

endmodule

// File: design/pipeline_register.sv
`timescale 1ns/1ps

module pipeline_register #(
    parameter type payload_t = logic
) (
    input  logic     i_clock,
    input  logic     i_reset,
    input  logic     i_enable,
    input  logic     i_flush,
    input  payload_t i_data,
    output payload_t o_data
);

    // One stage of payload, frozen while the debug unit holds enable low
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_data <= '0;
        end else if (i_enable) begin
            if (i_flush) begin
                o_data <= '0;  // Bubble wins over the incoming word
            end else begin
                o_data <= i_data;
            end
        end
    end

endmodule

// File: design/registers_bank.sv
`timescale 1ns/1ps

module registers_bank
    import decode_pkg::*;
#(
    parameter int NB_DATA    = decode_pkg::NB_DATA,
    parameter int NB_ADDR    = decode_pkg::NB_ADDR,
    parameter int BANK_DEPTH = decode_pkg::BANK_DEPTH
) (
    input  logic               i_clock,
    input  logic               i_reset,
    input  logic               i_enable,         // Step from the debug unit
    input  logic               i_reg_write,      // RegWrite from write-back
    input  logic [NB_ADDR-1:0] i_read_reg_a,
    input  logic [NB_ADDR-1:0] i_read_reg_b,
    input  logic [NB_ADDR-1:0] i_write_reg,
    input  logic [NB_DATA-1:0] i_write_data,
    input  logic               i_debug_read,
    input  logic [NB_ADDR-1:0] i_debug_address,
    output logic [NB_DATA-1:0] o_data_a,
    output logic [NB_DATA-1:0] o_data_b,
    output logic [NB_DATA-1:0] o_debug_data
);

    logic [NB_DATA-1:0] registers [BANK_DEPTH];

    // Reads take the value from before the edge, so a same-edge write is not seen
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                registers[i] <= '0;
            end
            o_data_a <= '0;
            o_data_b <= '0;
        end else if (i_enable) begin
            o_data_a <= registers[i_read_reg_a];
            o_data_b <= registers[i_read_reg_b];
            if (i_reg_write && (i_write_reg != '0)) begin  // r0 stays zero
                registers[i_write_reg] <= i_write_data;
            end
        end
    end

    // Debug port, no latency
    assign o_debug_data = i_debug_read ? registers[i_debug_address] : '0;

endmodule

// File: verif/decode_asserts.sv
`timescale 1ns/1ps

module decode_asserts
    import decode_pkg::*;
(
    input logic               i_clock,
    input logic               i_reset,
    input logic               i_enable,
    input logic               i_flush,
    input logic               i_debug_read,
    input id_ex_t             i_id_ex,
    input logic [NB_DATA-1:0] i_debug_data
);

    // Control bundle inactive right after a reset edge
    reset_clears_ctrl: assert property (
        @(posedge i_clock) i_reset |=> (i_id_ex.decoded.ctrl == '0)
    ) else $error("ID/EX control bundle not cleared by reset");

    // Enabled flush leaves a bubble in ID/EX
    flush_gives_bubble: assert property (
        @(posedge i_clock) (i_enable && i_flush && !i_reset) |=> (i_id_ex.decoded == '0)
    ) else $error("Flush at an enabled edge did not produce a bubble");

    debug_idle_zero: assert property (
        @(posedge i_clock) !i_debug_read |-> (i_debug_data == '0)
    ) else $error("Debug data not zero while the debug read is low");

endmodule

// File: verif/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top
    import decode_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int N_WB          = 40;
    localparam int N_RAND        = 200;
    localparam int N_BAD         = 40;
    localparam int N_FLUSH       = 20;
    localparam int N_HOLD        = 20;
    localparam int N_DRAIN       = 3;
    localparam int W             = $bits(id_ex_t);
    localparam int TEST_CYCLES   = RESET_CYCLES + 3 * BANK_DEPTH + N_WB + N_RAND + N_BAD
                                   + 3 * N_FLUSH + N_HOLD + N_DRAIN + 1;
    localparam int WATCHDOG_NS   = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic               i_clock;
    logic               i_reset;
    logic               i_enable;
    logic               i_flush;
    logic [31:0]        i_instruction;
    logic [NB_PC-1:0]   i_pc;
    logic               i_wb_write;
    logic [NB_ADDR-1:0] i_wb_reg;
    logic [NB_DATA-1:0] i_wb_data;
    logic               i_debug_read;
    logic [NB_ADDR-1:0] i_debug_address;
    id_ex_t             o_id_ex;
    logic [NB_DATA-1:0] o_debug_data;

    logic [31:0]        lfsr_state = 32'h96a1abd3;
    logic [NB_DATA-1:0] shadow [BANK_DEPTH];      // Model of the bank
    if_id_t             fetched [$];              // Words waiting in IF/ID
    if_id_t             head_word;
    if_id_t             new_word;
    id_ex_t             expected;
    logic               started = 1'b0;
    int                 n_checks = 0;
    int                 n_errors = 0;

    decode_top #(
        .NB_DATA    (NB_DATA),
        .NB_ADDR    (NB_ADDR),
        .BANK_DEPTH (BANK_DEPTH),
        .NB_PC      (NB_PC)
    ) DUT (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_enable        (i_enable),
        .i_flush         (i_flush),
        .i_instruction   (i_instruction),
        .i_pc            (i_pc),
        .i_wb_write      (i_wb_write),
        .i_wb_reg        (i_wb_reg),
        .i_wb_data       (i_wb_data),
        .i_debug_read    (i_debug_read),
        .i_debug_address (i_debug_address),
        .o_id_ex         (o_id_ex),
        .o_debug_data    (o_debug_data)
    );

    bind decode_top decode_asserts u_asserts (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_enable     (i_enable),
        .i_flush      (i_flush),
        .i_debug_read (i_debug_read),
        .i_id_ex      (o_id_ex),
        .i_debug_data (o_debug_data)
    );

    initial begin
        i_clock = 1'b0;
        forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit returned
    function automatic logic [31:0] draw(input int nbits);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic logic opcode_supported(input logic [5:0] op);
        return op inside {OP_RTYPE, OP_BEQ, OP_ADDI, OP_ANDI, OP_ORI, OP_LUI, OP_LW, OP_SW};
    endfunction

    function automatic logic funct_supported(input logic [5:0] fn);
        return fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
    endfunction

    function automatic logic [31:0] legal_instruction();
        logic [31:0] kind;
        logic [31:0] fields;
        logic [31:0] imm;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [31:0] word;
        kind   = draw(4);
        fields = draw(15);
        imm    = draw(16);
        op     = OP_RTYPE;
        fn     = FN_ADD;
        case (kind % 32'd12)
            32'd0:   fn = FN_ADD;
            32'd1:   fn = FN_SUB;
            32'd2:   fn = FN_AND;
            32'd3:   fn = FN_OR;
            32'd4:   fn = FN_SLT;
            32'd5:   op = OP_ADDI;
            32'd6:   op = OP_ANDI;
            32'd7:   op = OP_ORI;
            32'd8:   op = OP_LUI;
            32'd9:   op = OP_LW;
            32'd10:  op = OP_SW;
            default: op = OP_BEQ;
        endcase
        if (op == OP_RTYPE) begin
            word = {op, fields[14:0], 5'd0, fn};  // rs rt rd, shamt zero
        end else begin
            word = {op, fields[9:0], imm[15:0]};
        end
        return word;
    endfunction

    function automatic logic [31:0] illegal_instruction();
        logic [31:0] body;
        logic [31:0] r;
        body = draw(32);
        r    = draw(1);
        if (r[0]) begin
            while (funct_supported(body[5:0])) begin
                r         = draw(6);
                body[5:0] = r[5:0];
            end
            body[31:26] = OP_RTYPE;  // R-type with an unknown funct
        end else begin
            while (opcode_supported(body[31:26])) begin
                r           = draw(6);
                body[31:26] = r[5:0];
            end
        end
        return body;
    endfunction

    function automatic ctrl_t make_ctrl(input logic rw, input logic mr, input logic mw,
                                        input logic m2r, input logic src, input logic br,
                                        input alu_op_t op);
        ctrl_t c;
        c.reg_write  = rw;
        c.mem_read   = mr;
        c.mem_write  = mw;
        c.mem_to_reg = m2r;
        c.alu_src    = src;
        c.branch     = br;
        c.alu_op     = op;
        return c;
    endfunction

    // Expected ID/EX contents for one word, operands from the given bank state
    function automatic id_ex_t reference_decode(input logic [31:0] instr,
                                                input logic [NB_PC-1:0] pc,
                                                input logic [NB_DATA-1:0] regs [BANK_DEPTH]);
        id_ex_t      e;
        logic [31:0] sx;
        logic [31:0] zx;
        logic        known;
        alu_op_t     r_op;
        e       = '0;
        known   = 1'b1;
        r_op    = ALU_ADD;
        sx      = {{16{instr[15]}}, instr[15:0]};
        zx      = {16'h0, instr[15:0]};
        e.decoded.rs   = instr[25:21];
        e.decoded.rt   = instr[20:16];
        e.decoded.dest = instr[20:16];
        e.decoded.pc   = pc;
        case (instr[31:26])
            OP_RTYPE: begin
                case (instr[5:0])
                    FN_ADD:  r_op = ALU_ADD;
                    FN_SUB:  r_op = ALU_SUB;
                    FN_AND:  r_op = ALU_AND;
                    FN_OR:   r_op = ALU_OR;
                    FN_SLT:  r_op = ALU_SLT;
                    default: known = 1'b0;
                endcase
                e.decoded.dest = instr[15:11];
                e.decoded.ctrl = make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, r_op);
            end
            OP_ADDI: begin
                e.decoded.ctrl      = make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, ALU_ADD);
                e.decoded.immediate = sx;
            end
            OP_ANDI: begin
                e.decoded.ctrl      = make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, ALU_AND);
                e.decoded.immediate = zx;
            end
            OP_ORI: begin
                e.decoded.ctrl      = make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, ALU_OR);
                e.decoded.immediate = zx;
            end
            OP_LUI: begin
                e.decoded.ctrl      = make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, ALU_LUI);
                e.decoded.immediate = {instr[15:0], 16'h0};
            end
            OP_LW: begin
                e.decoded.ctrl      = make_ctrl(1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, ALU_ADD);
                e.decoded.immediate = sx;
            end
            OP_SW: begin
                e.decoded.ctrl      = make_ctrl(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, ALU_ADD);
                e.decoded.immediate = sx;
            end
            OP_BEQ: begin
                e.decoded.ctrl      = make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, ALU_SUB);
                e.decoded.immediate = sx;
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            e.decoded = '0;  // Bubble
        end
        e.data_a = regs[instr[25:21]];  // Operands are read even for a bubble
        e.data_b = regs[instr[20:16]];
        return e;
    endfunction

    task automatic check_value(input string what, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive(input logic en, input logic fl, input logic [31:0] instr,
                         input logic [NB_PC-1:0] pc, input logic we,
                         input logic [NB_ADDR-1:0] wreg, input logic [NB_DATA-1:0] wdata);
        @(negedge i_clock);
        i_enable      = en;
        i_flush       = fl;
        i_instruction = instr;
        i_pc          = pc;
        i_wb_write    = we;
        i_wb_reg      = wreg;
        i_wb_data     = wdata;
        i_debug_read  = 1'b0;
    endtask

    // Stage frozen while the port is read, value checked mid low phase
    task automatic read_register(input logic [NB_ADDR-1:0] addr);
        @(negedge i_clock);
        i_enable        = 1'b0;
        i_flush         = 1'b0;
        i_wb_write      = 1'b0;
        i_debug_read    = 1'b1;
        i_debug_address = addr;
        #(CLK_PERIOD / 4);
        check_value("debug read", W'(o_debug_data), W'(shadow[addr]));
        if (addr == '0) begin
            check_value("r0 debug read", W'(o_debug_data), '0);
        end
    endtask

    task automatic debug_sweep();
        for (int a = 0; a < BANK_DEPTH; a++) begin
            read_register(a[NB_ADDR-1:0]);
        end
    endtask

    // Model of the stage, sampled on the rising edge
    always @(posedge i_clock) begin
        started = 1'b1;
        if (i_reset) begin
            for (int k = 0; k < BANK_DEPTH; k++) begin
                shadow[k] = '0;
            end
            fetched.delete();
            fetched.push_back('0);
            expected = '0;
        end else if (i_enable) begin
            head_word = fetched.pop_front();
            expected  = reference_decode(head_word.instruction, head_word.pc, shadow);
            if (i_flush) begin
                expected.decoded = '0;
            end
            if (i_wb_write && (i_wb_reg != '0)) begin
                shadow[i_wb_reg] = i_wb_data;  // After the read, so old value is seen
            end
            new_word.instruction = i_instruction;
            new_word.pc          = i_pc;
            fetched.push_back(new_word);
        end
    end

    always @(negedge i_clock) begin
        if (started) begin
            check_value("o_id_ex", o_id_ex, expected);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0]        r;
        logic [31:0]        instr;
        logic [31:0]        wdata;
        logic [NB_PC-1:0]   pc;
        logic [NB_ADDR-1:0] prev_rs;
        logic [NB_ADDR-1:0] wreg;
        logic               en;
        logic               we;
        i_reset         = 1'b1;
        i_enable        = 1'b0;
        i_flush         = 1'b0;
        i_instruction   = '0;
        i_pc            = '0;
        i_wb_write      = 1'b0;
        i_wb_reg        = '0;
        i_wb_data       = '0;
        i_debug_read    = 1'b0;
        i_debug_address = '0;
        repeat (RESET_CYCLES) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        debug_sweep();

        for (int i = 0; i < N_WB; i++) begin
            r     = draw(5);
            wdata = draw(32);
            drive(1'b1, 1'b0, 32'h0, '0, 1'b1, r[4:0], wdata);
        end
        debug_sweep();

        pc      = 32'h0040_0000;
        prev_rs = '0;
        for (int i = 0; i < N_RAND; i++) begin
            instr = legal_instruction();
            r     = draw(3);
            en    = (r[2:0] != 3'd0);  // Occasional frozen edge
            r     = draw(6);
            we    = r[5];
            wreg  = r[4:0];
            wdata = draw(32);
            if (i % 4 == 3) begin
                we   = 1'b1;
                wreg = prev_rs;  // Write the source being read on this edge
            end
            drive(en, 1'b0, instr, pc, we, wreg, wdata);
            if (en) begin
                prev_rs = instr[25:21];
                pc      = pc + 32'd4;
            end
        end

        for (int i = 0; i < N_BAD; i++) begin
            instr = illegal_instruction();
            drive(1'b1, 1'b0, instr, pc, 1'b0, '0, '0);
        end

        // Flush hits the word loaded one edge earlier, the next word decodes
        for (int i = 0; i < N_FLUSH; i++) begin
            drive(1'b1, 1'b0, legal_instruction(), pc, 1'b0, '0, '0);
            drive(1'b1, 1'b1, legal_instruction(), pc + 32'd4, 1'b0, '0, '0);
            drive(1'b1, 1'b0, legal_instruction(), pc + 32'd8, 1'b0, '0, '0);
        end

        for (int i = 0; i < N_HOLD; i++) begin
            instr = legal_instruction();
            wdata = draw(32);
            r     = draw(6);
            drive(1'b0, r[5], instr, pc, 1'b1, r[4:0], wdata);
        end
        debug_sweep();

        repeat (N_DRAIN) drive(1'b1, 1'b0, 32'h0, '0, 1'b0, '0, '0);
        @(negedge i_clock);
        #(CLK_PERIOD / 4);
        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: vlog.f
design/decode_pkg.sv
design/pipeline_register.sv
design/control_unit.sv
design/registers_bank.sv
design/decode_top.sv
verif/decode_asserts.sv
verif/tb_decode_top.sv
